// File: hdl/zx_video_pkg.sv
/* widths, port addresses, line counts and enums shared by all stages
   of the ZX80/ZX81 display pipeline; each module imports what it needs */
package zx_video_pkg;

	// ==============================
	// bus and memory widths
	// ==============================
	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 8;
	localparam int ATTR_ADDR_W = 14;    // 16k attribute bytes
	localparam int ROW_W       = 3;     // 8 rows per character
	localparam int COLOR_W     = 4;     // IRGB
	localparam int CE_DIV_W    = 4;     // cpu enable every 16 clocks

	// ==============================
	// video timing
	// ==============================
	localparam int HSYNC_LAST   = 206;  // 207 counts per line
	localparam int HSYNC_START  = 16;
	localparam int HSYNC_END    = 31;
	localparam int LINE_W       = $clog2(HSYNC_LAST + 1);
	localparam int BACK_PORCH_W = 5;

	// chroma 81 control port and its power-up border
	localparam logic [ADDR_W-1:0]  CHROMA_PORT  = 16'h7FEF;
	localparam logic [COLOR_W-1:0] BORDER_RESET = 4'hF;

	// ==============================
	// enums
	// ==============================
	typedef enum logic {
		MODEL_ZX80,
		MODEL_ZX81
	} zx_model_e;

	typedef enum logic [2:0] {
		IO_NONE,
		IO_KBD_READ,        // IN from even port
		IO_NMI_ON,          // zx81 OUT to xx10
		IO_NMI_OFF,         // zx81 OUT to xx01
		IO_CHROMA_WRITE,
		IO_OTHER_WRITE
	} zx_io_op_e;

	typedef enum logic {
		CHR_CHARCODE,       // mode 0, attr looked up by code and row
		CHR_LATCHED         // mode 1, attr taken from the fetch address
	} chroma_mode_e;

endpackage

// File: hdl/zx_bus_timing.sv
/* stage 1: cpu clock enables, M1 edge detect and classification of
   the current I/O cycle; the model is sampled while reset is high */
`timescale 1ns/1ns

module zx_bus_timing (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic [zx_video_pkg::ADDR_W-1:0] addr_i,
	input  logic                            iorq_n_i,
	input  logic                            rd_n_i,
	input  logic                            wr_n_i,
	input  logic                            m1_n_i,
	input  logic                            mreq_n_i,
	input  logic                            rfsh_n_i,
	input  logic                            zx81_i,
	output logic                            ce_cpu_p_o,
	output logic                            ce_cpu_n_o,
	output logic                            ce_pix_o,
	output logic                            m1_fall_o,
	output zx_video_pkg::zx_io_op_e         io_op_o,
	output logic                            latch_en_o,
	output zx_video_pkg::zx_model_e         model_o
);
	import zx_video_pkg::*;

	logic [CE_DIV_W-1:0] div_cnt;
	logic [CE_DIV_W-1:0] div_nxt;
	logic                m1_d;

	assign div_nxt = div_cnt + 1'b1;

	// ==============================
	// clock enable divider
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt    <= '1;
			ce_cpu_p_o <= 1'b0;
			ce_cpu_n_o <= 1'b0;
			ce_pix_o   <= 1'b0;
			m1_d       <= 1'b1;
			m1_fall_o  <= 1'b0;
		end else begin
			div_cnt    <= div_nxt;
			ce_cpu_p_o <= ~div_nxt[CE_DIV_W-1] & (div_nxt[CE_DIV_W-2:0] == '0);
			ce_cpu_n_o <=  div_nxt[CE_DIV_W-1] & (div_nxt[CE_DIV_W-2:0] == '0);
			ce_pix_o   <= (div_nxt[CE_DIV_W-2:0] == '0);   // both cpu phases
			m1_d       <= m1_n_i;
			m1_fall_o  <= m1_d & ~m1_n_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			model_o <= zx_model_e'(zx81_i);  // held until next reset
	end

	// opcode fetch data strobe, outside refresh
	assign latch_en_o = rfsh_n_i & ~mreq_n_i & ce_cpu_n_o;

	// ==============================
	// I/O cycle classification
	// ==============================
	always_comb begin
		io_op_o = IO_NONE;
		if (!iorq_n_i) begin
			if (!rd_n_i && !addr_i[0])
				io_op_o = IO_KBD_READ;
			else if (!wr_n_i) begin
				if (addr_i == CHROMA_PORT)
					io_op_o = IO_CHROMA_WRITE;
				else if (model_o == MODEL_ZX81 && addr_i[1:0] == 2'b10)
					io_op_o = IO_NMI_ON;
				else if (model_o == MODEL_ZX81 && addr_i[1:0] == 2'b01)
					io_op_o = IO_NMI_OFF;
				else
					io_op_o = IO_OTHER_WRITE;
			end
		end
	end

endmodule

// File: hdl/zx_sync_gen.sv
/* stage 2: ZX80 sync flip-flop chain, ZX81 line counter with NMI latch,
   and the composite sync, NMI and WAIT derived from them */
`timescale 1ns/1ns

module zx_sync_gen (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ce_cpu_n_i,
	input  logic                    m1_fall_i,
	input  zx_video_pkg::zx_io_op_e io_op_i,
	input  logic                    iorq_n_i,
	input  logic                    m1_n_i,
	input  logic                    halt_n_i,
	input  zx_video_pkg::zx_model_e model_i,
	output logic                    csync_o,
	output logic                    vsync_o,
	output logic                    hsync_n_o,
	output logic                    nmi_latch_o,
	output logic                    nmi_n_o,
	output logic                    wait_n_o
);
	import zx_video_pkg::*;

	logic              ic18;        // sync preset
	logic              ic19_1;
	logic              ic19_2;      // zx80 composite sync
	logic              io_write;
	logic              sync_ok;
	logic [LINE_W-1:0] line_cnt;
	logic              zx80;

	assign zx80     = (model_i == MODEL_ZX80);
	assign io_write = (io_op_i == IO_NMI_ON) || (io_op_i == IO_NMI_OFF) ||
	                  (io_op_i == IO_CHROMA_WRITE) || (io_op_i == IO_OTHER_WRITE);
	assign sync_ok  = zx80 | ~nmi_latch_o;   // vsync frozen during zx81 nmi time

	// ==============================
	// zx80 sync flip-flops
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_o <= 1'b1;
			ic18    <= 1'b0;
			ic19_1  <= 1'b1;
			ic19_2  <= 1'b1;
		end else begin
			if (io_write && sync_ok)
				vsync_o <= 1'b1;                   // any OUT ends vsync
			if (io_op_i == IO_KBD_READ && sync_ok)
				vsync_o <= 1'b0;

			if (!iorq_n_i)
				ic18 <= 1'b1;
			if (!ic19_2)
				ic18 <= 1'b0;

			// preset reaches the sync pin two M1s later
			if (m1_fall_i) begin
				ic19_1 <= ~ic18;
				ic19_2 <= ic19_1;
			end
			if (!vsync_o)
				ic19_2 <= 1'b0;
		end
	end

	// ==============================
	// zx81 line counter and nmi latch
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			line_cnt    <= '0;
			nmi_latch_o <= 1'b0;
		end else begin
			if (ce_cpu_n_i) begin
				if (line_cnt == LINE_W'(HSYNC_LAST) || (!m1_n_i && !iorq_n_i))
					line_cnt <= '0;                // int ack restarts the line
				else
					line_cnt <= line_cnt + 1'b1;
			end
			if (io_op_i == IO_NMI_ON)
				nmi_latch_o <= 1'b1;
			else if (io_op_i == IO_NMI_OFF)
				nmi_latch_o <= 1'b0;
		end
	end

	assign hsync_n_o = ~(line_cnt >= LINE_W'(HSYNC_START) && line_cnt <= LINE_W'(HSYNC_END));
	assign csync_o   = zx80 ? ic19_2 : (vsync_o & hsync_n_o);
	assign nmi_n_o   = zx80 | ~(nmi_latch_o & ~hsync_n_o);
	assign wait_n_o  = zx80 | ~(halt_n_i & ~nmi_n_o);

endmodule

// File: hdl/zx_char_shifter.sv
/* stage 3: NOP forcing, character latch, pixel and paper shifters,
   row counter and back-porch blanking; drives the mono video bit */
`timescale 1ns/1ns

module zx_char_shifter (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            ce_cpu_p_i,
	input  logic                            ce_pix_i,
	input  logic                            latch_en_i,
	input  logic [zx_video_pkg::DATA_W-1:0] mem_data_i,
	input  logic [zx_video_pkg::ADDR_W-1:0] addr_i,
	input  logic                            mreq_n_i,
	input  logic                            m1_n_i,
	input  logic                            halt_n_i,
	input  logic                            csync_i,
	input  logic                            vsync_i,
	input  logic                            nmi_latch_i,
	input  zx_video_pkg::zx_model_e         model_i,
	input  logic                            inverse_video_i,
	output logic                            nop_o,
	output logic                            pixel_o,
	output logic                            border_o,
	output logic                            load_o,
	output logic [zx_video_pkg::DATA_W-1:0] char_code_o,
	output logic [zx_video_pkg::ROW_W-1:0]  row_o
);
	import zx_video_pkg::*;

	logic                    nopgen;
	logic                    nop_store;     // last fetch was display code
	logic                    shifter_start;
	logic                    start_d;
	logic [DATA_W-1:0]       shifter;
	logic [DATA_W-1:0]       paper;
	logic                    inverse;
	logic                    csync_d;
	logic [BACK_PORCH_W-1:0] back_porch;

	// fetch above 8000 with bit 6 clear is a character, not an opcode
	assign nopgen = addr_i[ADDR_W-1] & ~mem_data_i[6] & halt_n_i;
	assign nop_o  = ~m1_n_i & ~mreq_n_i & nopgen;

	assign shifter_start = mreq_n_i & nop_store & ((model_i == MODEL_ZX80) | ~nmi_latch_i);
	assign load_o        = ce_cpu_p_i & ~start_d & shifter_start;

	always_ff @(posedge clk_sys) begin
		if (reset)
			nop_store <= 1'b0;
		else if (latch_en_i)
			nop_store <= nopgen;
	end

	always_ff @(posedge clk_sys) begin
		if (latch_en_i)
			char_code_o <= mem_data_i;
	end

	// ==============================
	// pixel and paper shifters
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			start_d <= 1'b0;
			inverse <= 1'b0;
			shifter <= '0;
			paper   <= '0;
		end else begin
			if (ce_cpu_p_i)
				start_d <= shifter_start;
			if (mreq_n_i && ce_cpu_p_i)
				inverse <= 1'b0;
			if (load_o) begin
				shifter <= (!m1_n_i && nopgen) ? '0 : mem_data_i;
				inverse <= char_code_o[DATA_W-1];
				paper   <= '1;                 // reloaded on every char
			end else if (ce_pix_i) begin
				shifter <= {shifter[DATA_W-2:0], 1'b0};
				paper   <= {paper[DATA_W-2:0], 1'b0};
			end
		end
	end

	// ==============================
	// rows and back porch
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			csync_d    <= 1'b1;
			row_o      <= '0;
			back_porch <= BACK_PORCH_W'(1);
		end else begin
			csync_d <= csync_i;
			if (csync_d && !csync_i)
				row_o <= row_o + 1'b1;
			if (!vsync_i)
				row_o <= '0;

			if (!csync_d && csync_i)
				back_porch <= BACK_PORCH_W'(1);
			else if (ce_pix_i && back_porch != '0)
				back_porch <= back_porch + 1'b1;   // runs until wrap to 0
		end
	end

	assign border_o = ~paper[DATA_W-1];
	assign pixel_o  = (~inverse_video_i ^ shifter[DATA_W-1] ^ inverse) &
	                  (back_porch == '0) & csync_i;

endmodule

// File: hdl/chroma81_color.sv
/* stage 4: Chroma 81 port register, attribute RAM and the registered
   IRGB colour choice between border, ink, paper and plain mono */
`timescale 1ns/1ns

module chroma81_color (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic [zx_video_pkg::ADDR_W-1:0]  addr_i,
	input  logic [zx_video_pkg::DATA_W-1:0]  cpu_dout_i,
	input  logic                             mreq_n_i,
	input  logic                             wr_n_i,
	input  logic                             m1_n_i,
	input  logic                             rfsh_n_i,
	input  zx_video_pkg::zx_io_op_e          io_op_i,
	input  logic                             latch_en_i,
	input  logic                             load_i,
	input  logic                             pixel_i,
	input  logic                             border_i,
	input  logic [zx_video_pkg::DATA_W-1:0]  char_code_i,
	input  logic [zx_video_pkg::ROW_W-1:0]   row_i,
	input  logic                             chroma_en_i,
	output logic [zx_video_pkg::COLOR_W-1:0] color_o
);
	import zx_video_pkg::*;

	logic [DATA_W-1:0]      attr_ram [2**ATTR_ADDR_W];
	logic                   chr_ena;
	chroma_mode_e           chr_mode;
	logic [COLOR_W-1:0]     border_color;
	logic                   ram_we;
	logic [ATTR_ADDR_W-1:0] rd_addr;
	logic [DATA_W-1:0]      attr_dout;
	logic [DATA_W-1:0]      attr_latch;
	logic [DATA_W-1:0]      attr;
	logic                   chr_on;

	// ==============================
	// port register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			chr_ena      <= 1'b0;
			chr_mode     <= CHR_CHARCODE;
			border_color <= BORDER_RESET;
		end else if (io_op_i == IO_CHROMA_WRITE && chroma_en_i) begin
			chr_ena      <= cpu_dout_i[5];
			chr_mode     <= chroma_mode_e'(cpu_dout_i[4]);
			border_color <= cpu_dout_i[COLOR_W-1:0];
		end
	end

	// ==============================
	// attribute RAM, C000-FFFF
	// ==============================
	assign ram_we = chroma_en_i & (addr_i[ADDR_W-1:ADDR_W-2] == 2'b11) & m1_n_i &
	                ~mreq_n_i & ~wr_n_i;

	// refresh looks up code (bit 7 and 5..0) and row
	assign rd_addr = rfsh_n_i ? addr_i[ATTR_ADDR_W-1:0] :
	                 {{(ATTR_ADDR_W - ROW_W - 7){1'b0}}, char_code_i[7],
	                  char_code_i[5:0], row_i};

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			attr_ram[addr_i[ATTR_ADDR_W-1:0]] <= cpu_dout_i;
		attr_dout <= attr_ram[rd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (latch_en_i)
			attr_latch <= attr_dout;       // byte at the fetch address
		if (load_i)
			attr <= (chr_mode == CHR_LATCHED) ? attr_latch : attr_dout;
	end

	// ==============================
	// colour select
	// ==============================
	assign chr_on = chr_ena & chroma_en_i;

	always_ff @(posedge clk_sys) begin
		if (reset)
			color_o <= '0;
		else if (!chr_on)
			color_o <= {COLOR_W{pixel_i}};
		else if (border_i)
			color_o <= border_color;
		else if (pixel_i)
			color_o <= attr[DATA_W-1:COLOR_W];   // ink
		else
			color_o <= attr[COLOR_W-1:0];        // paper
	end

endmodule

// File: hdl/zx_video_top.sv
/* display generator top: bus timing, sync, character shifter and
   Chroma 81 colour stages joined to the Z80 bus and video outputs */
`timescale 1ns/1ns

module zx_video_top (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic [zx_video_pkg::ADDR_W-1:0]  bus_addr_i,
	input  logic [zx_video_pkg::DATA_W-1:0]  cpu_dout_i,
	input  logic [zx_video_pkg::DATA_W-1:0]  mem_data_i,
	input  logic                             mreq_n_i,
	input  logic                             iorq_n_i,
	input  logic                             rd_n_i,
	input  logic                             wr_n_i,
	input  logic                             m1_n_i,
	input  logic                             rfsh_n_i,
	input  logic                             halt_n_i,
	input  logic                             zx81_i,
	input  logic                             inverse_video_i,
	input  logic                             chroma_en_i,
	output logic                             ce_cpu_p_o,
	output logic                             ce_cpu_n_o,
	output logic                             ce_pix_o,
	output logic                             nop_o,
	output logic                             nmi_n_o,
	output logic                             wait_n_o,
	output logic                             csync_o,
	output logic                             vsync_o,
	output logic                             hsync_n_o,
	output logic [zx_video_pkg::COLOR_W-1:0] color_o
);
	import zx_video_pkg::*;

	logic              ce_cpu_p;
	logic              ce_cpu_n;
	logic              ce_pix;
	logic              m1_fall;
	zx_io_op_e         io_op;
	logic              latch_en;
	zx_model_e         model;
	logic              csync;
	logic              vsync;
	logic              nmi_latch;
	logic              pixel;
	logic              border;
	logic              load;
	logic [DATA_W-1:0] char_code;
	logic [ROW_W-1:0]  row;

	assign ce_cpu_p_o = ce_cpu_p;
	assign ce_cpu_n_o = ce_cpu_n;
	assign ce_pix_o   = ce_pix;
	assign csync_o    = csync;
	assign vsync_o    = vsync;

	zx_bus_timing zx_bus_timing_inst (
		.clk_sys, .reset,
		.addr_i(bus_addr_i), .iorq_n_i, .rd_n_i, .wr_n_i, .m1_n_i,
		.mreq_n_i, .rfsh_n_i, .zx81_i,
		.ce_cpu_p_o(ce_cpu_p), .ce_cpu_n_o(ce_cpu_n), .ce_pix_o(ce_pix),
		.m1_fall_o(m1_fall), .io_op_o(io_op), .latch_en_o(latch_en),
		.model_o(model)
	);

	zx_sync_gen zx_sync_gen_inst (
		.clk_sys, .reset,
		.ce_cpu_n_i(ce_cpu_n), .m1_fall_i(m1_fall), .io_op_i(io_op),
		.iorq_n_i, .m1_n_i, .halt_n_i, .model_i(model),
		.csync_o(csync), .vsync_o(vsync), .hsync_n_o, .nmi_latch_o(nmi_latch),
		.nmi_n_o, .wait_n_o
	);

	zx_char_shifter zx_char_shifter_inst (
		.clk_sys, .reset,
		.ce_cpu_p_i(ce_cpu_p), .ce_pix_i(ce_pix), .latch_en_i(latch_en),
		.mem_data_i, .addr_i(bus_addr_i), .mreq_n_i, .m1_n_i, .halt_n_i,
		.csync_i(csync), .vsync_i(vsync), .nmi_latch_i(nmi_latch),
		.model_i(model), .inverse_video_i,
		.nop_o, .pixel_o(pixel), .border_o(border), .load_o(load),
		.char_code_o(char_code), .row_o(row)
	);

	chroma81_color chroma81_color_inst (
		.clk_sys, .reset,
		.addr_i(bus_addr_i), .cpu_dout_i, .mreq_n_i, .wr_n_i, .m1_n_i, .rfsh_n_i,
		.io_op_i(io_op), .latch_en_i(latch_en), .load_i(load),
		.pixel_i(pixel), .border_i(border), .char_code_i(char_code),
		.row_i(row), .chroma_en_i, .color_o
	);

endmodule

// File: verification/zx_video_tb.sv
/* testbench for the display generator: drives Z80 bus cycles in ZX81 mode
   and checks sync, NMI/WAIT, NOP forcing, mono and Chroma 81 pixel output */
`timescale 1ns/1ns

module zx_video_tb;
	import zx_video_pkg::*;

	logic               clk_sys = 1'b0;
	logic               reset;
	logic [ADDR_W-1:0]  bus_addr_i;
	logic [DATA_W-1:0]  cpu_dout_i;
	logic [DATA_W-1:0]  mem_data_i;
	logic               mreq_n_i, iorq_n_i, rd_n_i, wr_n_i;
	logic               m1_n_i, rfsh_n_i, halt_n_i;
	logic               zx81_i, inverse_video_i, chroma_en_i;
	logic               ce_cpu_p_o, ce_cpu_n_o, ce_pix_o, nop_o;
	logic               nmi_n_o, wait_n_o, csync_o, vsync_o, hsync_n_o;
	logic [COLOR_W-1:0] color_o;

	int                 checks = 0;
	int                 errors = 0;
	int                 test_start_errs = 0;
	int                 pix_left = 0;           // pixels still to compare
	logic [8*COLOR_W-1:0] exp_seq;
	logic               hung = 1'b0;            // set by a wait that ran out
	string              hang_what;

	zx_video_top zx_video_top_inst (
		.clk_sys, .reset, .bus_addr_i, .cpu_dout_i, .mem_data_i,
		.mreq_n_i, .iorq_n_i, .rd_n_i, .wr_n_i, .m1_n_i, .rfsh_n_i, .halt_n_i,
		.zx81_i, .inverse_video_i, .chroma_en_i,
		.ce_cpu_p_o, .ce_cpu_n_o, .ce_pix_o, .nop_o, .nmi_n_o, .wait_n_o,
		.csync_o, .vsync_o, .hsync_n_o, .color_o
	);

	always #10 clk_sys = ~clk_sys;

	// ==============================
	// compare tasks and reference
	// ==============================
	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_color(input string what, input logic [COLOR_W-1:0] got,
	                           input logic [COLOR_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: counted %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// 8 colours, MSB first, for one character cell
	function automatic logic [8*COLOR_W-1:0] expected_colors(
		input logic [DATA_W-1:0] pix, input logic [DATA_W-1:0] code,
		input logic iv, input logic chr_on, input logic [DATA_W-1:0] attr);
		logic [8*COLOR_W-1:0] seq;
		logic                 b;
		for (int k = 0; k < 8; k++) begin
			b = ~iv ^ pix[DATA_W-1-k] ^ code[DATA_W-1];
			if (chr_on)
				seq[k*COLOR_W +: COLOR_W] = b ? attr[DATA_W-1:COLOR_W] : attr[COLOR_W-1:0];
			else
				seq[k*COLOR_W +: COLOR_W] = {COLOR_W{b}};
		end
		return seq;
	endfunction

	always begin
		@(posedge clk_sys);
		#1;
		if (pix_left > 0 && ce_pix_o) begin
			check_color("pixel colour", color_o, exp_seq[(8-pix_left)*COLOR_W +: COLOR_W]);
			pix_left--;
		end
	end

	// ==============================
	// waits and bus cycles
	// ==============================
	task automatic timeout(input string what);
		hang_what = what;
		hung      = 1'b1;
		forever @(posedge clk_sys);
	endtask

	always @(posedge clk_sys) begin
		if (hung) begin
			$display("timeout while waiting for %s", hang_what);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic wait_cpu_p;
		int n;
		@(posedge clk_sys);
		#1;
		n = 1;
		while (!ce_cpu_p_o && n < 40) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (!ce_cpu_p_o)
			timeout("the cpu clock enable");
	endtask

	task automatic wait_hsync(input logic level);
		int n;
		@(posedge clk_sys);
		#1;
		n = 1;
		while (hsync_n_o !== level && n < 4000) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (hsync_n_o !== level)
			timeout("horizontal sync");
	endtask

	task automatic bus_idle;
		bus_addr_i = '0;
		mreq_n_i   = 1'b1;
		iorq_n_i   = 1'b1;
		rd_n_i     = 1'b1;
		wr_n_i     = 1'b1;
		m1_n_i     = 1'b1;
		rfsh_n_i   = 1'b1;
		mem_data_i = 8'hFF;     // bit 6 set, never a display code
	endtask

	task automatic io_cycle(input logic [ADDR_W-1:0] addr, input logic wr,
	                        input logic [DATA_W-1:0] data);
		wait_cpu_p;
		#1;
		bus_addr_i = addr;
		cpu_dout_i = data;
		iorq_n_i   = 1'b0;
		rd_n_i     = wr;
		wr_n_i     = ~wr;
		wait_cpu_p;
		#1;
		bus_idle;
	endtask

	task automatic mem_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		wait_cpu_p;
		#1;
		bus_addr_i = addr;
		cpu_dout_i = data;
		mreq_n_i   = 1'b0;
		wr_n_i     = 1'b0;
		wait_cpu_p;
		#1;
		bus_idle;
	endtask

	// start of a line with row 0 and the back porch over
	task automatic prepare_line;
		int n;
		int m;
		wait_hsync(1'b0);
		wait_hsync(1'b1);
		io_cycle(16'h00FE, 1'b0, 8'h00);
		io_cycle(16'h00FF, 1'b1, 8'h00);
		n = 0;
		m = 0;
		while (n < 32 && m < 400) begin
			@(posedge clk_sys);
			#1;
			m++;
			if (ce_pix_o)
				n++;
		end
		if (n < 32)
			timeout("the end of the back porch");
	endtask

	// M1 fetch of a display code, refresh with the pixel byte, then load
	task automatic pixel_run(input logic [ADDR_W-1:0] faddr, input logic [DATA_W-1:0] code,
	                         input logic [DATA_W-1:0] pix, input logic chr_on,
	                         input logic [DATA_W-1:0] attr);
		int n;
		prepare_line;
		wait_cpu_p;
		#1;
		bus_addr_i = faddr;
		mem_data_i = code;
		m1_n_i     = 1'b0;
		mreq_n_i   = 1'b0;
		rd_n_i     = 1'b0;
		#1;
		check_bit("nop forced", nop_o, 1'b1);
		wait_cpu_p;
		#1;
		bus_addr_i = 16'h1E00;
		mem_data_i = pix;
		m1_n_i     = 1'b1;
		rd_n_i     = 1'b1;
		rfsh_n_i   = 1'b0;
		wait_cpu_p;
		#1;
		mreq_n_i = 1'b1;                    // shifter loads on this cpu enable
		exp_seq  = expected_colors(pix, code, inverse_video_i, chr_on, attr);
		pix_left = 8;
		@(posedge clk_sys);
		#2;
		bus_addr_i = '0;                    // plain fetch keeps the inverse bit
		mem_data_i = 8'h00;
		rfsh_n_i   = 1'b1;
		m1_n_i     = 1'b0;
		mreq_n_i   = 1'b0;
		rd_n_i     = 1'b0;
		n = 0;
		while (pix_left > 0 && n < 200) begin
			@(posedge clk_sys);
			#2;
			n++;
		end
		if (pix_left > 0)
			timeout("the pixel comparison");
		bus_idle;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s", name, (errors == test_start_errs) ? "ok" : "failed");
		test_start_errs = errors;
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial begin
		int                 n;
		int                 low;
		logic [DATA_W-1:0]  code;
		logic [DATA_W-1:0]  pix;
		logic [DATA_W-1:0]  attr;
		logic [COLOR_W-1:0] brd;
		logic [ADDR_W-1:0]  faddr;
		n = $urandom(12);
		reset           = 1'b1;
		cpu_dout_i      = '0;
		halt_n_i        = 1'b1;
		zx81_i          = 1'b1;
		inverse_video_i = 1'b0;
		chroma_en_i     = 1'b1;
		bus_idle;
		repeat (8) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		check_bit("ce_cpu_p in reset", ce_cpu_p_o, 1'b0);
		check_bit("nmi_n", nmi_n_o, 1'b1);
		check_bit("wait_n", wait_n_o, 1'b1);
		check_bit("vsync", vsync_o, 1'b1);
		check_bit("csync", csync_o, 1'b1);
		@(posedge clk_sys);
		#1;
		check_bit("first ce_cpu_p", ce_cpu_p_o, 1'b1);
		for (int i = 1; i <= 16; i++) begin
			@(posedge clk_sys);
			#1;
			check_bit("ce_cpu_n", ce_cpu_n_o, i == 8);
			check_bit("ce_pix", ce_pix_o, i == 8 || i == 16);
			check_bit("ce_cpu_p period", ce_cpu_p_o, i == 16);
		end
		end_test("1 reset state");

		wait_hsync(1'b0);
		n = 0;
		while (!hsync_n_o && n < 1000) begin
			n++;
			@(posedge clk_sys);
			#1;
		end
		check_count("hsync low cycles", n, 256);
		while (hsync_n_o && n < 5000) begin
			n++;
			@(posedge clk_sys);
			#1;
		end
		check_count("line period", n, (HSYNC_LAST + 1) * 16);
		end_test("2 zx81 hsync");

		io_cycle(16'h00FE, 1'b1, 8'h00);
		low = 0;
		for (int i = 0; i < (HSYNC_LAST + 1) * 16; i++) begin
			@(posedge clk_sys);
			#1;
			check_bit("nmi_n follows hsync", nmi_n_o, hsync_n_o);
			check_bit("wait_n", wait_n_o, ~(halt_n_i & ~hsync_n_o));
			if (!nmi_n_o)
				low++;
			#1;
			halt_n_i = ~halt_n_i;           // both halt levels in the nmi window
		end
		halt_n_i = 1'b1;
		check_count("nmi low cycles", low, 256);
		io_cycle(16'h00FD, 1'b1, 8'h00);
		low = 0;
		for (int i = 0; i < (HSYNC_LAST + 1) * 16; i++) begin
			@(posedge clk_sys);
			#1;
			if (!nmi_n_o)
				low++;
		end
		check_count("nmi low after FD", low, 0);
		end_test("3 zx81 nmi");

		io_cycle(16'h00FE, 1'b0, 8'h00);
		check_bit("vsync after IN", vsync_o, 1'b0);
		check_bit("csync after IN", csync_o, 1'b0);
		io_cycle(16'h00FF, 1'b1, 8'h00);
		check_bit("vsync after OUT", vsync_o, 1'b1);
		check_bit("csync after OUT", csync_o, hsync_n_o);
		end_test("4 vsync");

		inverse_video_i = 1'b1;
		code = 8'($urandom) & 8'hBF;
		pix  = 8'($urandom);
		pixel_run(16'h8000 | (16'($urandom) & 16'h3FFF), code, pix, 1'b0, 8'h00);
		inverse_video_i = 1'b0;
		code = 8'($urandom) & 8'hBF;
		pix  = 8'($urandom);
		pixel_run(16'h8000 | (16'($urandom) & 16'h3FFF), code, pix, 1'b0, 8'h00);
		end_test("5 nop and mono pixels");

		brd = 4'($urandom % 15);            // never the reset border
		io_cycle(CHROMA_PORT, 1'b1, {4'b0010, brd});
		repeat (2) @(posedge clk_sys);
		#1;
		check_color("border colour", color_o, brd);
		code = 8'($urandom) & 8'hBF;
		pix  = 8'($urandom);
		attr = 8'($urandom);
		mem_write(16'hC000 | {code[7], code[5:0], 3'b000}, attr);
		pixel_run(16'h8000 | (16'($urandom) & 16'h1FFF), code, pix, 1'b1, attr);
		io_cycle(CHROMA_PORT, 1'b1, {4'b0011, brd});
		code  = 8'($urandom) & 8'hBF;
		pix   = 8'($urandom);
		attr  = 8'($urandom);
		faddr = 16'hA000 | (16'($urandom) & 16'h1FFF);
		mem_write(16'hC000 | faddr[ATTR_ADDR_W-1:0], attr);
		pixel_run(faddr, code, pix, 1'b1, attr);
		end_test("6 chroma 81");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: sources.f
hdl/zx_video_pkg.sv
hdl/zx_bus_timing.sv
hdl/zx_sync_gen.sv
hdl/zx_char_shifter.sv
hdl/chroma81_color.sv
hdl/zx_video_top.sv
verification/zx_video_tb.sv

// File: Bender.yml
package:
  name: zx_video

sources:
  - hdl/zx_video_pkg.sv
  - hdl/zx_bus_timing.sv
  - hdl/zx_sync_gen.sv
  - hdl/zx_char_shifter.sv
  - hdl/chroma81_color.sv
  - hdl/zx_video_top.sv
  - target: test
    files:
      - verification/zx_video_tb.sv
